// File: axis_demux_user.sv
/* User read-data demultiplexer
   Steers a counted burst of the input stream to one response or receive port */

`timescale 1ns/1ps

`include "stream_route_cfg.svh"

module axis_demux_user (
  input  logic                                            aclk,
  input  logic                                            aresetn,

  // Descriptor in from the arbiter
  input  logic                                            arb_valid,
  output logic                                            arb_ready,
  input  stream_route_pkg::req_t                          arb_data,

  // Descriptor out to the queue
  output logic                                            fwd_valid,
  input  logic                                            fwd_ready,
  output stream_route_pkg::req_t                          fwd_data,

  // Shared input stream
  input  logic                                            s_axis_tvalid,
  output logic                                            s_axis_tready,
  input  logic [`SR_DATA_BITS-1:0]                        s_axis_tdata,
  input  logic [stream_route_pkg::KEEP_BITS-1:0]          s_axis_tkeep,
  input  logic                                            s_axis_tlast,

  // Response ports
  output logic [`SR_N_DESTS-1:0]                          m_resp_tvalid,
  input  logic [`SR_N_DESTS-1:0]                          m_resp_tready,
  output logic [`SR_N_DESTS-1:0][`SR_DATA_BITS-1:0]       m_resp_tdata,
  output logic [`SR_N_DESTS-1:0][stream_route_pkg::KEEP_BITS-1:0] m_resp_tkeep,
  output logic [`SR_N_DESTS-1:0]                          m_resp_tlast,
  output logic [`SR_N_DESTS-1:0][`SR_PID_BITS-1:0]        m_resp_tid,

  // Receive ports
  output logic [`SR_N_DESTS-1:0]                          m_recv_tvalid,
  input  logic [`SR_N_DESTS-1:0]                          m_recv_tready,
  output logic [`SR_N_DESTS-1:0][`SR_DATA_BITS-1:0]       m_recv_tdata,
  output logic [`SR_N_DESTS-1:0][stream_route_pkg::KEEP_BITS-1:0] m_recv_tkeep,
  output logic [`SR_N_DESTS-1:0]                          m_recv_tlast,
  output logic [`SR_N_DESTS-1:0][`SR_PID_BITS-1:0]        m_recv_tid
);

  typedef enum logic [1:0] {ST_IDLE, ST_MUX_RESP, ST_MUX_RECV} state_t;

  state_t state_q, state_d;

  // Current transfer, count holds remaining beats minus one
  logic [stream_route_pkg::DEST_BITS-1:0] dest_q, dest_d;
  logic [`SR_PID_BITS-1:0]                pid_q, pid_d;
  logic [stream_route_pkg::CNT_BITS-1:0]  cnt_q, cnt_d;

  logic [`SR_LEN_BITS-1:0] len_m1;
  logic                    beat_fire;
  logic                    tr_done;
  logic                    take;
  logic                    is_resp;

  // --------------------------------------------------
  // Beat steering
  // --------------------------------------------------
  always_comb begin
    for (int i = 0; i < `SR_N_DESTS; i++) begin
      // Payload broadcast, only tvalid is steered
      m_resp_tdata[i] = s_axis_tdata;
      m_resp_tkeep[i] = s_axis_tkeep;
      m_resp_tlast[i] = s_axis_tlast;
      m_resp_tid[i]   = pid_q;
      m_recv_tdata[i] = s_axis_tdata;
      m_recv_tkeep[i] = s_axis_tkeep;
      m_recv_tlast[i] = s_axis_tlast;
      m_recv_tid[i]   = pid_q;

      m_resp_tvalid[i] = (state_q == ST_MUX_RESP) && (dest_q == i) && s_axis_tvalid;
      m_recv_tvalid[i] = (state_q == ST_MUX_RECV) && (dest_q == i) && s_axis_tvalid;
    end

    // Out of range dest leaves the stream stalled
    if (dest_q < `SR_N_DESTS && state_q == ST_MUX_RESP) begin
      s_axis_tready = m_resp_tready[dest_q];
    end else if (dest_q < `SR_N_DESTS && state_q == ST_MUX_RECV) begin
      s_axis_tready = m_recv_tready[dest_q];
    end else begin
      s_axis_tready = 1'b0;
    end
  end

  // --------------------------------------------------
  // Descriptor acceptance
  // --------------------------------------------------
  assign beat_fire = s_axis_tvalid && s_axis_tready;

  // Count alone ends a transfer, tlast is ignored
  assign tr_done = (state_q != ST_IDLE) && (cnt_q == '0) && beat_fire;

  // Next descriptor chains onto the last beat
  assign take = arb_valid && fwd_ready && ((state_q == ST_IDLE) || tr_done);

  assign arb_ready = take;
  assign fwd_valid = take;
  assign fwd_data  = arb_data;

  assign is_resp = (arb_data.opcode == stream_route_pkg::OP_RD_RESP);

  // Bytes minus one, divided by bytes per beat
  assign len_m1 = arb_data.len - 1'b1;

  // Next state and datapath
  always_comb begin
    state_d = state_q;
    dest_d  = dest_q;
    pid_d   = pid_q;
    cnt_d   = cnt_q;

    if (take) begin
      state_d = is_resp ? ST_MUX_RESP : ST_MUX_RECV;
      dest_d  = arb_data.dest;
      pid_d   = arb_data.pid;
      cnt_d   = len_m1[`SR_LEN_BITS-1:stream_route_pkg::BEAT_LOG_BITS];
    end else if (tr_done) begin
      state_d = ST_IDLE;
    end else if (beat_fire) begin
      cnt_d = cnt_q - 1'b1;
    end
  end

  // --------------------------------------------------
  // Registers
  // --------------------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Transfer fields, qualified by the state
  always_ff @(posedge aclk) begin
    dest_q <= dest_d;
    pid_q  <= pid_d;
    cnt_q  <= cnt_d;
  end

endmodule

// File: filelist.f
+incdir+.
stream_route_pkg.sv
req_arbiter.sv
meta_queue.sv
axis_demux_user.sv
stream_route_top.sv
stream_route_assert.sv
tb_stream_route.sv

// File: meta_queue.sv
/* Descriptor queue
   Small synchronous FIFO between the demultiplexer and the request output */

`timescale 1ns/1ps

`include "stream_route_cfg.svh"

module meta_queue #(
  parameter int DATA_BITS = 32
) (
  input  logic                 aclk,
  input  logic                 aresetn,

  // Write side
  input  logic                 s_valid,
  output logic                 s_ready,
  input  logic [DATA_BITS-1:0] s_data,

  // Read side
  output logic                 m_valid,
  input  logic                 m_ready,
  output logic [DATA_BITS-1:0] m_data
);

  localparam int DEPTH    = `SR_QUEUE_DEPTH;
  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  // Descriptor storage
  logic [DATA_BITS-1:0] mem [DEPTH];

  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;

  logic do_wr;
  logic do_rd;

  // Full blocks writes even when a read is pending
  assign s_ready = (count != CNT_BITS'(DEPTH));
  assign m_valid = (count != '0);

  // Output taken from flops through the read mux only
  assign m_data = mem[rd_ptr];

  assign do_wr = s_valid && s_ready;
  assign do_rd = m_valid && m_ready;

  // Payload write
  always_ff @(posedge aclk) begin
    if (do_wr) begin
      mem[wr_ptr] <= s_data;
    end
  end

  // --------------------------------------------------
  // Pointers and fill count
  // --------------------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Explicit wrap keeps non power of two depths legal
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous read and write leave the count alone
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// File: req_arbiter.sv
/* Round-robin request arbiter
   Grants one peer source at a time onto the shared descriptor path */

`timescale 1ns/1ps

`include "stream_route_cfg.svh"

module req_arbiter (
  input  logic                                      aclk,
  input  logic                                      aresetn,

  // Peer sources
  input  logic [`SR_N_SRCS-1:0]                     src_req_valid,
  output logic [`SR_N_SRCS-1:0]                     src_req_ready,
  input  stream_route_pkg::req_t [`SR_N_SRCS-1:0]   src_req_data,

  // Shared path to the demultiplexer
  output logic                                      arb_valid,
  input  logic                                      arb_ready,
  output stream_route_pkg::req_t                    arb_data
);

  localparam int N_SRCS   = `SR_N_SRCS;
  localparam int SRC_BITS = (N_SRCS > 1) ? $clog2(N_SRCS) : 1;

  // Last accepted source
  logic [SRC_BITS-1:0] last_q;

  // Winner of the current cycle
  logic [SRC_BITS-1:0] win_idx;
  logic                win_found;
  logic [N_SRCS-1:0]   grant;

  // --------------------------------------------------
  // Grant selection
  // --------------------------------------------------
  // Scan starts one past the last winner and wraps,
  // the last winner itself is checked last
  always_comb begin
    int cand;

    win_found = 1'b0;
    win_idx   = last_q;
    grant     = '0;

    for (int i = 1; i <= N_SRCS; i++) begin
      cand = (int'(last_q) + i) % N_SRCS;
      if (!win_found && src_req_valid[cand]) begin
        win_found = 1'b1;
        win_idx   = SRC_BITS'(cand);
      end
    end

    // One-hot grant, empty when nobody asks
    grant[win_idx] = win_found;
  end

  // --------------------------------------------------
  // Shared path
  // --------------------------------------------------
  assign arb_valid = win_found;
  assign arb_data  = src_req_data[win_idx];

  // Only the granted source sees the downstream ready
  assign src_req_ready = grant & {N_SRCS{arb_ready}};

  // --------------------------------------------------
  // Priority pointer
  // --------------------------------------------------
  // Starts on the last source so source 0 wins first,
  // moves only on an accepted grant
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      last_q <= SRC_BITS'(N_SRCS - 1);
    end else if (arb_valid && arb_ready) begin
      last_q <= win_idx;
    end
  end

endmodule

// File: stream_route_assert.sv
/* Stream router protocol checks
   Handshake, payload, destination and routing rules on the top level */

`timescale 1ns/1ps

`include "stream_route_cfg.svh"

module stream_route_assert (
  input logic                                     aclk,
  input logic                                     aresetn,
  input logic [`SR_N_SRCS-1:0]                    src_req_valid,
  input logic [`SR_N_SRCS-1:0]                    src_req_ready,
  input stream_route_pkg::req_t [`SR_N_SRCS-1:0]  src_req_data,
  input logic                                     arb_valid,
  input logic                                     arb_ready,
  input stream_route_pkg::req_t                   arb_data,
  input logic [`SR_N_DESTS-1:0]                   m_resp_tvalid,
  input logic [`SR_N_DESTS-1:0]                   m_recv_tvalid
);

  // Ready only reaches a source that asks
  assert property (@(posedge aclk) disable iff (!aresetn)
    (src_req_ready & ~src_req_valid) == '0)
    else $error("source ready raised without its valid");

  // A waiting descriptor holds its payload
  for (genvar i = 0; i < `SR_N_SRCS; i++) begin : g_src
    assert property (@(posedge aclk) disable iff (!aresetn)
      src_req_valid[i] && !src_req_ready[i] |=> $stable(src_req_data[i]))
      else $error("source %0d changed its descriptor while waiting", i);
  end

  // Out of range dest would stall the stream
  assert property (@(posedge aclk) disable iff (!aresetn)
    arb_valid && arb_ready |-> int'(arb_data.dest) < `SR_N_DESTS)
    else $error("accepted descriptor has a dest out of range");

  // One routed port at a time
  assert property (@(posedge aclk) disable iff (!aresetn)
    $onehot0({m_resp_tvalid, m_recv_tvalid}))
    else $error("more than one output tvalid high");

endmodule

// File: stream_route_cfg.svh
/* Stream router configuration
   Widths, counts and queue depth shared by the router blocks */

`ifndef STREAM_ROUTE_CFG_SVH
`define STREAM_ROUTE_CFG_SVH

// --------------------------------------------------
// Data stream
// --------------------------------------------------
// Beat width in bits, keep is one bit per byte
`define SR_DATA_BITS 64

// --------------------------------------------------
// Requests and routing
// --------------------------------------------------
// Peer request sources into the arbiter
`define SR_N_SRCS 3
// Destinations, each with a response and a receive port
`define SR_N_DESTS 4
// Process id carried on tid
`define SR_PID_BITS 6
// Transfer length in bytes
`define SR_LEN_BITS 16

// Entries in the forwarded-descriptor queue
`define SR_QUEUE_DEPTH 4

`endif

// File: stream_route_pkg.sv
/* Stream router types
   Opcodes, descriptor layout and widths derived from the configuration */

`include "stream_route_cfg.svh"

package stream_route_pkg;

  // Bytes per beat and its base-2 log
  localparam int KEEP_BITS     = `SR_DATA_BITS / 8;
  localparam int BEAT_LOG_BITS = $clog2(KEEP_BITS);

  // Destination index, at least one bit
  localparam int DEST_BITS = (`SR_N_DESTS > 1) ? $clog2(`SR_N_DESTS) : 1;

  // Remaining beats minus one, enough for the largest length
  localparam int CNT_BITS = `SR_LEN_BITS - BEAT_LOG_BITS;

  // Only a read response goes to the response ports
  typedef enum logic [1:0] {
    OP_RD_RESP    = 2'd0,
    OP_RECV_SEND  = 2'd1,
    OP_RECV_WRITE = 2'd2
  } opcode_t;

  // Transfer descriptor, opcode in the top bits
  typedef struct packed {
    opcode_t                  opcode;
    logic [DEST_BITS-1:0]     dest;
    logic [`SR_PID_BITS-1:0]  pid;
    logic [`SR_LEN_BITS-1:0]  len;
  } req_t;

endpackage

// File: stream_route_top.sv
/* Stream router top level
   Arbiter, demultiplexer and descriptor queue */

`timescale 1ns/1ps

`include "stream_route_cfg.svh"

module stream_route_top (
  input  logic                                            aclk,
  input  logic                                            aresetn,

  // Request sources
  input  logic [`SR_N_SRCS-1:0]                           src_req_valid,
  output logic [`SR_N_SRCS-1:0]                           src_req_ready,
  input  stream_route_pkg::req_t [`SR_N_SRCS-1:0]         src_req_data,

  // Input data stream
  input  logic                                            s_axis_tvalid,
  output logic                                            s_axis_tready,
  input  logic [`SR_DATA_BITS-1:0]                        s_axis_tdata,
  input  logic [stream_route_pkg::KEEP_BITS-1:0]          s_axis_tkeep,
  input  logic                                            s_axis_tlast,

  // Response ports
  output logic [`SR_N_DESTS-1:0]                          m_resp_tvalid,
  input  logic [`SR_N_DESTS-1:0]                          m_resp_tready,
  output logic [`SR_N_DESTS-1:0][`SR_DATA_BITS-1:0]       m_resp_tdata,
  output logic [`SR_N_DESTS-1:0][stream_route_pkg::KEEP_BITS-1:0] m_resp_tkeep,
  output logic [`SR_N_DESTS-1:0]                          m_resp_tlast,
  output logic [`SR_N_DESTS-1:0][`SR_PID_BITS-1:0]        m_resp_tid,

  // Receive ports
  output logic [`SR_N_DESTS-1:0]                          m_recv_tvalid,
  input  logic [`SR_N_DESTS-1:0]                          m_recv_tready,
  output logic [`SR_N_DESTS-1:0][`SR_DATA_BITS-1:0]       m_recv_tdata,
  output logic [`SR_N_DESTS-1:0][stream_route_pkg::KEEP_BITS-1:0] m_recv_tkeep,
  output logic [`SR_N_DESTS-1:0]                          m_recv_tlast,
  output logic [`SR_N_DESTS-1:0][`SR_PID_BITS-1:0]        m_recv_tid,

  // Forwarded descriptors
  output logic                                            m_req_valid,
  input  logic                                            m_req_ready,
  output stream_route_pkg::req_t                          m_req_data
);

  // Arbiter to demultiplexer
  logic                   arb_valid;
  logic                   arb_ready;
  stream_route_pkg::req_t arb_data;

  // Demultiplexer to queue
  logic                   fwd_valid;
  logic                   fwd_ready;
  stream_route_pkg::req_t fwd_data;

  req_arbiter req_arbiter_inst (.*);

  axis_demux_user axis_demux_user_inst (.*);

  meta_queue #(
    .DATA_BITS($bits(stream_route_pkg::req_t))
  ) meta_queue_inst (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_valid (fwd_valid),
    .s_ready (fwd_ready),
    .s_data  (fwd_data),
    .m_valid (m_req_valid),
    .m_ready (m_req_ready),
    .m_data  (m_req_data)
  );

endmodule

// File: tb_stream_route.sv
/* Stream router testbench
   Round-robin sources, counted bursts on routed ports, forwarding queue stall */

`timescale 1ns/1ps

`include "stream_route_cfg.svh"

module tb_stream_route;

  localparam int N_SRCS      = `SR_N_SRCS;
  localparam int N_DESTS     = `SR_N_DESTS;
  localparam int N_PER       = 8;
  localparam int N_DESCS     = N_SRCS * N_PER;
  localparam int BYTES       = `SR_DATA_BITS / 8;
  localparam int MAX_BEATS   = N_DESCS * 64 / BYTES;

  logic                                     aclk = 1'b0;
  logic                                     aresetn;
  logic [N_SRCS-1:0]                        src_req_valid;
  logic [N_SRCS-1:0]                        src_req_ready;
  stream_route_pkg::req_t [N_SRCS-1:0]      src_req_data;
  logic                                     s_axis_tvalid;
  logic                                     s_axis_tready;
  logic [`SR_DATA_BITS-1:0]                 s_axis_tdata;
  logic [BYTES-1:0]                         s_axis_tkeep;
  logic                                     s_axis_tlast;
  logic [N_DESTS-1:0]                       m_resp_tvalid;
  logic [N_DESTS-1:0]                       m_resp_tready;
  logic [N_DESTS-1:0]                       m_resp_tlast;
  logic [N_DESTS-1:0][`SR_DATA_BITS-1:0]    m_resp_tdata;
  logic [N_DESTS-1:0][BYTES-1:0]            m_resp_tkeep;
  logic [N_DESTS-1:0][`SR_PID_BITS-1:0]     m_resp_tid;
  logic [N_DESTS-1:0]                       m_recv_tvalid;
  logic [N_DESTS-1:0]                       m_recv_tready;
  logic [N_DESTS-1:0]                       m_recv_tlast;
  logic [N_DESTS-1:0][`SR_DATA_BITS-1:0]    m_recv_tdata;
  logic [N_DESTS-1:0][BYTES-1:0]            m_recv_tkeep;
  logic [N_DESTS-1:0][`SR_PID_BITS-1:0]     m_recv_tid;
  logic                                     m_req_valid;
  logic                                     m_req_ready;
  stream_route_pkg::req_t                   m_req_data;

  // Stimulus and expected traffic
  stream_route_pkg::req_t   descs [N_SRCS][N_PER];
  stream_route_pkg::req_t   ord_desc [N_DESCS];
  logic [`SR_DATA_BITS-1:0] beat_data [MAX_BEATS];
  logic [BYTES-1:0]         beat_keep [MAX_BEATS];
  logic                     beat_last [MAX_BEATS];
  logic [`SR_PID_BITS-1:0]  beat_tid [MAX_BEATS];
  int                       beat_port [MAX_BEATS];
  int exp_ptr [2*N_DESTS];
  int src_idx [N_SRCS];
  int n_beats = 0;
  int hold_beats = 0;
  int beat_idx = 0;
  int beats_seen = 0;
  int req_ptr = 0;
  int acc_count = 0;
  int cycles = 0;
  int limit = 1000000;
  logic run = 1'b0;
  logic hold_req = 1'b1;
  logic [31:0] lcg_state = 32'hf632;
  logic [31:0] r;

  always #4 aclk = ~aclk;

  stream_route_top stream_route_top_inst (.*);

  bind stream_route_top stream_route_assert stream_route_assert_inst (.*);

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // First asking source strictly after the last winner
  function automatic int rr_pick(input logic [N_SRCS-1:0] asking, input int last);
    int win;
    win = -1;
    for (int i = N_SRCS; i >= 1; i--) begin
      if (asking[(last + i) % N_SRCS]) win = (last + i) % N_SRCS;
    end
    return win;
  endfunction

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  // Sources stay valid while they hold descriptors,
  // so the acceptance order follows from the pointer alone
  function automatic void build_expected();
    int used [N_SRCS];
    logic [N_SRCS-1:0] asking;
    int last;
    int win;
    stream_route_pkg::req_t d;
    last = N_SRCS - 1;
    for (int s = 0; s < N_SRCS; s++) used[s] = 0;
    for (int k = 0; k < N_DESCS; k++) begin
      for (int s = 0; s < N_SRCS; s++) asking[s] = (used[s] < N_PER);
      win = rr_pick(asking, last);
      d = descs[win][used[win]];
      used[win] += 1;
      last = win;
      ord_desc[k] = d;
      // One beat per started group of BYTES bytes
      for (int b = int'(d.len); b > 0; b -= BYTES) begin
        beat_data[n_beats] = {lcg_next(), lcg_next()};
        beat_keep[n_beats] = (b >= BYTES) ? '1 : BYTES'((1 << b) - 1);
        beat_last[n_beats] = (b <= BYTES);
        beat_tid[n_beats]  = d.pid;
        // Read responses on the response side and all else on receive
        beat_port[n_beats] = (d.opcode == stream_route_pkg::OP_RD_RESP) ?
                             int'(d.dest) : N_DESTS + int'(d.dest);
        n_beats += 1;
      end
      // Beats that pass before the held queue fills
      if (k == `SR_QUEUE_DEPTH - 1) hold_beats = n_beats;
    end
  endfunction

  task automatic fail_run();
    $display("test failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [`SR_DATA_BITS-1:0] got,
                             input logic [`SR_DATA_BITS-1:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED: %s got %h expected %h", name, got, exp);
      fail_run();
    end
  endtask

  // Next expected beat of this port in global stream order
  task automatic check_beat(input int p, input logic [`SR_DATA_BITS-1:0] data,
                            input logic [BYTES-1:0] keep, input logic last,
                            input logic [`SR_PID_BITS-1:0] tid);
    string fam;
    int idx;
    int k;
    fam = (p < N_DESTS) ? "m_resp" : "m_recv";
    idx = p % N_DESTS;
    k = exp_ptr[p];
    while (k < n_beats && beat_port[k] != p) k += 1;
    assert (k < n_beats) else begin
      $display("%s[%0d] carried a beat that no descriptor sent there", fam, idx);
      fail_run();
    end
    check_value($sformatf("%s_tdata[%0d]", fam, idx), data, beat_data[k]);
    check_value($sformatf("%s_tkeep[%0d]", fam, idx), keep, beat_keep[k]);
    check_value($sformatf("%s_tlast[%0d]", fam, idx), last, beat_last[k]);
    check_value($sformatf("%s_tid[%0d]", fam, idx), tid, beat_tid[k]);
    exp_ptr[p] = k + 1;
    beats_seen += 1;
  endtask

  task automatic check_idle();
    check_value("m_resp_tvalid", m_resp_tvalid, '0);
    check_value("m_recv_tvalid", m_recv_tvalid, '0);
    check_value("src_req_ready", src_req_ready, '0);
    check_value("m_req_valid", m_req_valid, 1'b0);
  endtask

  // --------------------------------------------------
  // Drivers
  // --------------------------------------------------
  // Each source walks its own list in order
  always @(posedge aclk) begin
    for (int s = 0; s < N_SRCS; s++) begin
      if (src_req_valid[s] && src_req_ready[s]) src_idx[s] += 1;
      src_req_valid[s] <= run && (src_idx[s] < N_PER);
      src_req_data[s]  <= descs[s][src_idx[s] % N_PER];
    end
  end

  // Beats presented in predicted descriptor order
  // Valid is up from the first edge and the idle FSM must hold the ports quiet
  always @(posedge aclk) begin
    if (s_axis_tvalid && s_axis_tready) beat_idx += 1;
    s_axis_tvalid <= (beat_idx < n_beats);
    s_axis_tdata  <= beat_data[beat_idx % MAX_BEATS];
    s_axis_tkeep  <= beat_keep[beat_idx % MAX_BEATS];
    s_axis_tlast  <= beat_last[beat_idx % MAX_BEATS];
  end

  // Random stalls on about one cycle in four per port
  always @(posedge aclk) begin
    r = lcg_next();
    m_resp_tready <= r[19:16] | r[23:20];
    m_recv_tready <= r[27:24] | r[31:28];
    m_req_ready   <= !hold_req && (r[30] || r[29]);
  end

  // --------------------------------------------------
  // Comparing process and timeout
  // --------------------------------------------------
  always @(posedge aclk) begin
    if (run) begin
      for (int p = 0; p < N_DESTS; p++) begin
        if (m_resp_tvalid[p] && m_resp_tready[p])
          check_beat(p, m_resp_tdata[p], m_resp_tkeep[p], m_resp_tlast[p], m_resp_tid[p]);
        if (m_recv_tvalid[p] && m_recv_tready[p])
          check_beat(N_DESTS + p, m_recv_tdata[p], m_recv_tkeep[p], m_recv_tlast[p],
                     m_recv_tid[p]);
      end
      if (m_req_valid && m_req_ready) begin
        assert (req_ptr < N_DESCS) else begin
          $display("m_req delivered more descriptors than were issued");
          fail_run();
        end
        check_value("m_req_data", m_req_data, ord_desc[req_ptr]);
        req_ptr += 1;
      end
      acc_count += $countones(src_req_valid & src_req_ready);
    end
  end

  always @(posedge aclk) begin
    cycles += 1;
    assert (cycles < limit) else begin
      $display("timeout after %0d cycles", cycles);
      fail_run();
    end
  end

  initial begin
    aresetn       = 1'b0;
    src_req_valid = '0;
    src_req_data  = '0;
    s_axis_tvalid = 1'b0;
    s_axis_tdata  = '0;
    s_axis_tkeep  = '0;
    s_axis_tlast  = 1'b0;
    m_resp_tready = '0;
    m_recv_tready = '0;
    m_req_ready   = 1'b0;
    for (int p = 0; p < 2 * N_DESTS; p++) exp_ptr[p] = 0;
    for (int s = 0; s < N_SRCS; s++) begin
      src_idx[s] = 0;
      for (int i = 0; i < N_PER; i++) begin
        r = lcg_next();
        descs[s][i].opcode = stream_route_pkg::opcode_t'(r[31:24] % 3);
        descs[s][i].dest   = r[23:16] % N_DESTS;
        descs[s][i].pid    = `SR_PID_BITS'(r >> 10);
        descs[s][i].len    = `SR_LEN_BITS'(1 + (lcg_next() >> 16) % 64);
      end
    end
    // Edge lengths around the beat size
    descs[0][0].len = 1;
    descs[1][0].len = 8;
    descs[2][0].len = 9;
    descs[0][1].len = 64;
    build_expected();
    limit = 20 * (n_beats + N_DESCS);

    // Reset held for 10 edges, then two idle cycles checked
    @(posedge aclk);
    for (int i = 2; i <= 12; i++) begin
      @(posedge aclk);
      check_idle();
      if (i == 10) aresetn <= 1'b1;
    end
    run <= 1'b1;

    // Only the queue depth gets in while the queue output is held
    while (beats_seen < hold_beats) @(posedge aclk);
    repeat (8) @(posedge aclk);
    check_value("accepted descriptors", acc_count, `SR_QUEUE_DEPTH);
    check_value("beats while held", beats_seen, hold_beats);
    check_value("m_req_valid", m_req_valid, 1'b1);
    hold_req <= 1'b0;

    while (beats_seen < n_beats || req_ptr < N_DESCS) @(posedge aclk);
    repeat (5) @(posedge aclk);
    if (beats_seen == n_beats && req_ptr == N_DESCS && acc_count == N_DESCS) begin
      $display("test passed");
      $finish;
    end else begin
      $display("accepted descriptor count differs from the issued count");
      fail_run();
    end
  end

endmodule
